// File: bench/rv_exec_chk.sv
`timescale 1ns/1ps

module rv_exec_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        instr_valid,
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [31:0] rs1_data,
    input logic [31:0] rs2_data,
    input logic        out_valid,
    input logic        rd_write,
    input logic [4:0]  rd_addr,
    input logic [31:0] rd_wdata,
    input logic        branch_taken,
    input logic [31:0] branch_target,
    input logic        illegal_instr
);

    typedef struct packed {
        logic        ill;
        logic        wr;
        logic        wd;
        logic        tk;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic [31:0] tgt;
    } expect_t;

    expect_t e1;
    expect_t e2;
    logic    v1 = 1'b0;
    logic    v2 = 1'b0;
    logic    armed = 1'b0;
    int      fail_count = 0;

    // Reference model of one RV32I instruction
    function automatic expect_t predict(input logic [31:0] i, input logic [31:0] p,
                                        input logic [31:0] a, input logic [31:0] b);
        expect_t     e;
        logic [31:0] imm_i;
        logic [31:0] y;
        logic [2:0]  f3;
        logic        alt;
        logic        lt_s;
        logic        lt_u;
        logic        is_br;
        f3    = i[14:12];
        alt   = i[31:25] == 7'h20;
        imm_i = {{20{i[31]}}, i[31:20]};
        y     = i[5] ? b : imm_i;
        lt_u  = a < y;
        // With differing signs the negative one is smaller
        lt_s  = (a[31] != y[31]) ? a[31] : lt_u;
        e     = '0;
        e.rd  = i[11:7];
        is_br = i[6:0] == 7'h63;
        case (i[6:0])
            7'h33, 7'h13: begin
                case (f3)
                    3'd0: e.wdata = (alt && i[5]) ? a - y : a + y;
                    3'd1: e.wdata = a << y[4:0];
                    3'd2: e.wdata = {31'd0, lt_s};
                    3'd3: e.wdata = {31'd0, lt_u};
                    3'd4: e.wdata = a ^ y;
                    3'd5: e.wdata = (alt && a[31]) ? ~(~a >> y[4:0]) : a >> y[4:0];
                    3'd6: e.wdata = a | y;
                    default: e.wdata = a & y;
                endcase
                if (i[5]) begin
                    e.ill = i[31:25] != 7'h00 && !(alt && (f3 == 3'd0 || f3 == 3'd5));
                end else begin
                    e.ill = (f3 == 3'd1 && i[31:25] != 7'h00) ||
                            (f3 == 3'd5 && i[31:25] != 7'h00 && !alt);
                end
            end
            7'h37: e.wdata = {i[31:12], 12'h000};
            7'h17: e.wdata = p + {i[31:12], 12'h000};
            7'h6f: begin
                e.wdata = p + 32'd4;
                e.tk    = 1'b1;
                e.tgt   = p + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            7'h67: begin
                e.wdata = p + 32'd4;
                e.tk    = 1'b1;
                e.tgt   = (a + imm_i) & 32'hffff_fffe;
                e.ill   = f3 != 3'd0;
            end
            7'h63: begin
                e.tgt = p + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
                case (f3)
                    3'd0: e.tk = a == b;
                    3'd1: e.tk = a != b;
                    3'd4: e.tk = lt_s;
                    3'd5: e.tk = !lt_s;
                    3'd6: e.tk = lt_u;
                    3'd7: e.tk = !lt_u;
                    default: e.ill = 1'b1;
                endcase
            end
            default: e.ill = 1'b1;
        endcase
        e.wd = !e.ill && !is_br;
        e.wr = e.wd && e.rd != 5'd0;
        e.tk = e.tk && !e.ill;
        return e;
    endfunction

    // Two instructions in flight
    always @(posedge clk) begin
        armed <= 1'b1;
        v1    <= rst_n && instr_valid;
        v2    <= rst_n && v1;
        e1    <= predict(instr, pc, rs1_data, rs2_data);
        e2    <= e1;
    end

    valid_a: assert property (@(posedge clk) disable iff (!armed) out_valid == v2)
        else begin
            $error("mismatch at %0t: out_valid expected %b actual %b",
                   $time, $sampled(v2), $sampled(out_valid));
            fail_count = fail_count + 1;
        end

    write_a: assert property (@(posedge clk) disable iff (!armed) rd_write == (v2 && e2.wr))
        else begin
            $error("mismatch at %0t: rd_write expected %b actual %b",
                   $time, $sampled(v2 && e2.wr), $sampled(rd_write));
            fail_count = fail_count + 1;
        end

    taken_a: assert property (@(posedge clk) disable iff (!armed)
                              branch_taken == (v2 && e2.tk))
        else begin
            $error("mismatch at %0t: branch_taken expected %b actual %b",
                   $time, $sampled(v2 && e2.tk), $sampled(branch_taken));
            fail_count = fail_count + 1;
        end

    illegal_a: assert property (@(posedge clk) disable iff (!armed)
                                illegal_instr == (v2 && e2.ill))
        else begin
            $error("mismatch at %0t: illegal_instr expected %b actual %b",
                   $time, $sampled(v2 && e2.ill), $sampled(illegal_instr));
            fail_count = fail_count + 1;
        end

    addr_a: assert property (@(posedge clk) disable iff (!armed) v2 |-> rd_addr == e2.rd)
        else begin
            $error("mismatch at %0t: rd_addr expected %0d actual %0d",
                   $time, $sampled(e2.rd), $sampled(rd_addr));
            fail_count = fail_count + 1;
        end

    wdata_a: assert property (@(posedge clk) disable iff (!armed)
                              v2 && e2.wd |-> rd_wdata == e2.wdata)
        else begin
            $error("mismatch at %0t: rd_wdata expected %h actual %h",
                   $time, $sampled(e2.wdata), $sampled(rd_wdata));
            fail_count = fail_count + 1;
        end

    target_a: assert property (@(posedge clk) disable iff (!armed)
                               v2 && e2.tk |-> branch_target == e2.tgt)
        else begin
            $error("mismatch at %0t: branch_target expected %h actual %h",
                   $time, $sampled(e2.tgt), $sampled(branch_target));
            fail_count = fail_count + 1;
        end

endmodule

bind rv_exec_top rv_exec_chk chk0 (.*);

// File: bench/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        out_valid;
    logic        rd_write;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        illegal_instr;
    integer      seed;
    integer      issued;
    integer      retired;
    integer      wait_cycles;

    rv_exec_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Builds one instruction of class kind with free fields taken from r
    function automatic logic [31:0] make_instr(input logic [3:0] kind, input logic [31:0] r);
        logic [31:0] i;
        i = r;
        case (kind)
            4'd0, 4'd1: begin
                i[6:0]   = 7'h33;
                i[31:25] = 7'h00;
                if (r[6]) begin
                    i[31:25] = 7'h20;
                    i[14:12] = r[12] ? 3'd5 : 3'd0;
                end
            end
            4'd2, 4'd3: begin
                i[6:0] = 7'h13;
                // Shift immediates
                if (i[13:12] == 2'b01) begin
                    i[31:25] = (r[6] && r[14]) ? 7'h20 : 7'h00;
                end
            end
            4'd4: i[6:0] = 7'h37;
            4'd5: i[6:0] = 7'h17;
            4'd6: i[6:0] = 7'h6f;
            4'd7: begin
                i[6:0]   = 7'h67;
                i[14:12] = 3'd0;
            end
            4'd8, 4'd9: begin
                i[6:0] = 7'h63;
                if (i[14:13] == 2'b01) begin
                    i[13] = 1'b0;
                end
            end
            default: begin
                i[6:0] = 7'h33;
                case (r[2:0])
                    3'd0: i[6:0] = 7'h03;
                    3'd1: i[6:0] = 7'h73;
                    3'd2: i[25] = 1'b1;
                    3'd3: begin
                        i[31:25] = 7'h20;
                        i[13]    = 1'b1;
                    end
                    3'd4: begin
                        i[6:0]   = 7'h13;
                        i[14:12] = 3'd1;
                        i[25]    = 1'b1;
                    end
                    3'd5: begin
                        i[6:0]   = 7'h13;
                        i[14:12] = 3'd5;
                        i[25]    = 1'b1;
                    end
                    3'd6: begin
                        i[6:0] = 7'h67;
                        i[12]  = 1'b1;
                    end
                    default: begin
                        i[6:0]   = 7'h63;
                        i[14:12] = {2'b01, r[12]};
                    end
                endcase
            end
        endcase
        return i;
    endfunction

    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ins;
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            instr_valid <= 1'b0;
        end else begin
            a   = $random(seed);
            b   = $random(seed);
            ins = make_instr(r[11:8] % 4'd11, $random(seed));
            // Equal operands and x0 targets now and then
            if (r[4:2] == 3'b000) begin
                b = a;
            end
            if (r[15:13] == 3'b000) begin
                ins[11:7] = 5'd0;
            end
            instr_valid <= 1'b1;
            instr       <= ins;
            pc          <= $random(seed);
            rs1_data    <= a;
            rs2_data    <= b;
            issued = issued + 1;
        end
    endtask

    always @(negedge clk) begin
        if (out_valid) begin
            retired <= retired + 1;
        end
    end

    always @(negedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an output check in the bound checker failed");
        end
    end

    initial begin
        seed        = 99061;
        issued      = 0;
        retired     = 0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h0;
        pc          = 32'h0;
        rs1_data    = 32'h0;
        rs2_data    = 32'h0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (issued < 2000) begin
            @(posedge clk);
            issue_random();
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        wait_cycles = 0;
        while (retired != issued && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        @(negedge clk);
        if (retired != issued) begin
            $display("ERRORS FOUND");
            $fatal(1, "timed out waiting for the last results to come out");
        end else if (dut0.chk0.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an output check in the bound checker failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv_exec_tb -f rv_exec.f -o rv_exec_sim \
    && ./obj_dir/rv_exec_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: rv_exec.f
src/rv_exec_pkg.sv
src/rv_alu.sv
src/rv_decode_stage.sv
src/rv_execute_stage.sv
src/rv_exec_top.sv
bench/rv_exec_chk.sv
bench/rv_exec_tb.sv

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_exec_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                // Arithmetic shift keeps the sign bit
                result = word_t'($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: src/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      d_valid,
    output logic      d_illegal,
    output reg_addr_t d_rd_addr,
    output rd_sel_t   d_rd_sel,
    output alu_op_t   d_alu_op,
    output br_op_t    d_br_op,
    output logic      d_is_branch,
    output logic      d_is_jump,
    output word_t     d_alu_a,
    output word_t     d_alu_b,
    output word_t     d_pc,
    output word_t     d_imm,
    output word_t     d_rs1,
    output word_t     d_rs2,
    output logic      d_jump_reg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       dec_illegal;
    alu_op_t    dec_alu_op;
    br_op_t     dec_br_op;
    rd_sel_t    dec_rd_sel;
    logic       dec_is_branch;
    logic       dec_is_jump;
    logic       dec_jump_reg;
    logic       dec_use_imm;
    word_t      dec_imm;

    function automatic alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec_illegal   = 1'b0;
        dec_alu_op    = ALU_ADD;
        dec_br_op     = BR_EQ;
        dec_rd_sel    = RD_ALU;
        dec_is_branch = 1'b0;
        dec_is_jump   = 1'b0;
        dec_jump_reg  = 1'b0;
        dec_use_imm   = 1'b1;
        dec_imm       = imm_i;
        case (opcode)
            OPCODE_OP: begin
                dec_use_imm = 1'b0;
                dec_alu_op  = alu_op_of(funct3, funct7 == FUNCT7_ALT);
                if (funct7 != 7'd0 && funct7 != FUNCT7_ALT) begin
                    dec_illegal = 1'b1;
                end else if (funct7 == FUNCT7_ALT && funct3 != F3_ADD && funct3 != F3_SR) begin
                    dec_illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: begin
                // Upper bits are only an opcode extension for shifts
                dec_alu_op = alu_op_of(funct3, funct3 == F3_SR && funct7 == FUNCT7_ALT);
                if (funct3 == F3_SLL && funct7 != 7'd0) begin
                    dec_illegal = 1'b1;
                end
                if (funct3 == F3_SR && funct7 != 7'd0 && funct7 != FUNCT7_ALT) begin
                    dec_illegal = 1'b1;
                end
            end
            OPCODE_LUI: begin
                dec_rd_sel = RD_UPPER;
                dec_imm    = imm_u;
            end
            OPCODE_AUIPC: begin
                dec_rd_sel = RD_AUIPC;
                dec_imm    = imm_u;
            end
            OPCODE_JAL: begin
                dec_rd_sel  = RD_LINK;
                dec_is_jump = 1'b1;
                dec_imm     = imm_j;
            end
            OPCODE_JALR: begin
                dec_rd_sel   = RD_LINK;
                dec_is_jump  = 1'b1;
                dec_jump_reg = 1'b1;
                dec_illegal  = funct3 != 3'd0;
            end
            OPCODE_BRANCH: begin
                dec_is_branch = 1'b1;
                dec_imm       = imm_b;
                case (funct3)
                    F3_BEQ:  dec_br_op = BR_EQ;
                    F3_BNE:  dec_br_op = BR_NE;
                    F3_BLT:  dec_br_op = BR_LT;
                    F3_BGE:  dec_br_op = BR_GE;
                    F3_BLTU: dec_br_op = BR_LTU;
                    F3_BGEU: dec_br_op = BR_GEU;
                    default: dec_illegal = 1'b1;
                endcase
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            d_illegal   <= dec_illegal;
            d_rd_addr   <= instr[11:7];
            d_rd_sel    <= dec_rd_sel;
            d_alu_op    <= dec_alu_op;
            d_br_op     <= dec_br_op;
            d_is_branch <= dec_is_branch;
            d_is_jump   <= dec_is_jump;
            d_jump_reg  <= dec_jump_reg;
            d_alu_a     <= rs1_data;
            d_alu_b     <= dec_use_imm ? dec_imm : rs2_data;
            d_pc        <= pc;
            d_imm       <= dec_imm;
            d_rs1       <= rs1_data;
            d_rs2       <= rs2_data;
        end
    end

endmodule

// File: src/rv_exec_pkg.sv
package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes of the kept RV32I subset
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'd0;
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_op_t;

    // Source of the destination register value
    typedef enum logic [1:0] {RD_ALU, RD_UPPER, RD_AUIPC, RD_LINK} rd_sel_t;

endpackage

// File: src/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      out_valid,
    output logic      rd_write,
    output reg_addr_t rd_addr,
    output word_t     rd_wdata,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      illegal_instr
);

    // Decode to execute
    logic      d_valid;
    logic      d_illegal;
    reg_addr_t d_rd_addr;
    rd_sel_t   d_rd_sel;
    alu_op_t   d_alu_op;
    br_op_t    d_br_op;
    logic      d_is_branch;
    logic      d_is_jump;
    word_t     d_alu_a;
    word_t     d_alu_b;
    word_t     d_pc;
    word_t     d_imm;
    word_t     d_rs1;
    word_t     d_rs2;
    logic      d_jump_reg;

    rv_decode_stage decode0 (.*);

    rv_execute_stage execute0 (.*);

endmodule

// File: src/rv_execute_stage.sv
`timescale 1ns/1ps

module rv_execute_stage import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      d_valid,
    input  logic      d_illegal,
    input  reg_addr_t d_rd_addr,
    input  rd_sel_t   d_rd_sel,
    input  alu_op_t   d_alu_op,
    input  br_op_t    d_br_op,
    input  logic      d_is_branch,
    input  logic      d_is_jump,
    input  word_t     d_alu_a,
    input  word_t     d_alu_b,
    input  word_t     d_pc,
    input  word_t     d_imm,
    input  word_t     d_rs1,
    input  word_t     d_rs2,
    input  logic      d_jump_reg,
    output logic      out_valid,
    output logic      rd_write,
    output reg_addr_t rd_addr,
    output word_t     rd_wdata,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      illegal_instr
);

    word_t alu_result;
    word_t pc_plus_imm;
    word_t result;
    word_t target;
    logic  cond;
    logic  legal;

    rv_alu alu0 (
        .alu_op (d_alu_op),
        .a      (d_alu_a),
        .b      (d_alu_b),
        .result (alu_result)
    );

    assign pc_plus_imm = d_pc + d_imm;
    assign legal       = d_valid && !d_illegal;

    always_comb begin
        case (d_rd_sel)
            RD_ALU:   result = alu_result;
            RD_UPPER: result = d_imm;
            RD_AUIPC: result = pc_plus_imm;
            RD_LINK:  result = d_pc + 32'd4;
            default:  result = alu_result;
        endcase
    end

    always_comb begin
        case (d_br_op)
            BR_EQ:   cond = d_rs1 == d_rs2;
            BR_NE:   cond = d_rs1 != d_rs2;
            BR_LT:   cond = $signed(d_rs1) < $signed(d_rs2);
            BR_GE:   cond = $signed(d_rs1) >= $signed(d_rs2);
            BR_LTU:  cond = d_rs1 < d_rs2;
            BR_GEU:  cond = d_rs1 >= d_rs2;
            default: cond = 1'b0;
        endcase
    end

    // JALR target drops bit 0
    assign target = d_jump_reg ? ((d_rs1 + d_imm) & ~32'd1) : pc_plus_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            rd_write      <= 1'b0;
            branch_taken  <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            out_valid     <= d_valid;
            // Writes to x0 never leave the stage
            rd_write      <= legal && !d_is_branch && (d_rd_addr != 5'd0);
            branch_taken  <= legal && (d_is_jump || (d_is_branch && cond));
            illegal_instr <= d_valid && d_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid) begin
            rd_addr       <= d_rd_addr;
            rd_wdata      <= result;
            branch_target <= target;
        end
    end

endmodule
